// File: qrisc_defs.svh
// qrisc decode stage widths, register count and instruction field positions
`ifndef QRISC_DEFS_SVH
`define QRISC_DEFS_SVH

`define QRISC_DATA_W      32
`define QRISC_REG_CNT     32
`define QRISC_REG_ADDR_W  5
`define QRISC_INCR_W      4

// instruction fields, used directly as bit ranges
`define QRISC_OPCODE_F    31:28
`define QRISC_SUBOP_F     27:26
`define QRISC_ALUOP_F     27:25
// set means offset comes from R2
`define QRISC_ROFS_BIT    25
`define QRISC_INCR_F      24:22
`define QRISC_OFS_F       24:10
`define QRISC_OFS_SIGN    24
`define QRISC_OFS_W       15
`define QRISC_HALF_F      20:5
`define QRISC_HALF_W      16
`define QRISC_TARGET_F    25:0
`define QRISC_TARGET_W    26
`define QRISC_DST_F       4:0
`define QRISC_SRC1_F      9:5
`define QRISC_SRC2_F      14:10

`endif

// File: qrisc_pkg.sv
// qrisc decode stage types
// opcode, alu and jump encodings plus the write-back, read and pipeline structs
`include "qrisc_defs.svh"

package qrisc_pkg;

    typedef logic [`QRISC_REG_ADDR_W-1:0] reg_addr_t;

    ////////////////////////////////////////////////////////////
    // encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_NOP    = 4'd0,
        OP_LDR    = 4'd1,
        OP_STR    = 4'd2,
        OP_JMPUNC = 4'd3,
        OP_JMPF   = 4'd4,
        OP_ALU    = 4'd5,
        OP_LDRF   = 4'd6   // codes above are invalid
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_NONE,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_ADD,
        ALU_MUL,
        ALU_SHL,
        ALU_SHR,
        ALU_CMP
    } alu_op_e;

    typedef enum logic [2:0] {
        JMP_NONE,
        JMP_UNC,
        JMP_Z,
        JMP_NZ,
        JMP_C,
        JMP_NC
    } jump_e;

    ////////////////////////////////////////////////////////////
    // structs
    ////////////////////////////////////////////////////////////

    // write-back from execute or memory stage
    typedef struct packed {
        logic                      write_reg;
        reg_addr_t                 dst_r;
        logic [`QRISC_DATA_W-1:0]  val_dst;
        logic                      incr_r2_enable;
        reg_addr_t                 src_r2;
        logic [`QRISC_DATA_W-1:0]  val_r2;
    } wb_t;

    typedef struct packed {
        reg_addr_t r1;
        reg_addr_t r2;
        reg_addr_t dst;
    } rd_addr_t;

    typedef struct packed {
        logic [`QRISC_DATA_W-1:0] val_r1;
        logic [`QRISC_DATA_W-1:0] val_r2;
        logic [`QRISC_DATA_W-1:0] val_dst;
    } operand_t;

    // decoded instruction handed to execute
    typedef struct packed {
        reg_addr_t                        dst_r;
        reg_addr_t                        src_r1;
        reg_addr_t                        src_r2;
        logic [`QRISC_DATA_W-1:0]         val_r1;
        logic [`QRISC_DATA_W-1:0]         val_r2;
        logic [`QRISC_DATA_W-1:0]         val_dst;
        logic signed [`QRISC_INCR_W-1:0]  incr_r2;
        logic                             incr_r2_enable;
        logic                             read_mem;
        logic                             write_mem;
        logic                             write_reg;
        alu_op_e                          alu_op;
        jump_e                            jmp_cond;
        logic                             ldrf_op;
    } pipe_t;

endpackage

// File: reg_file.sv
// qrisc register file
// 32 x 32 bit, three write ports from the write-back paths, three async reads
`include "qrisc_defs.svh"
`timescale 1ns/1ns

module reg_file (
    input  logic                 clk,
    input  logic                 reset,
    input  qrisc_pkg::wb_t       wb_ex,
    input  qrisc_pkg::wb_t       wb_mem,
    input  qrisc_pkg::rd_addr_t  rd_addr,
    output qrisc_pkg::operand_t  rd_data
);

    logic [`QRISC_DATA_W-1:0] regs [`QRISC_REG_CNT];

    ////////////////////////////////////////////////////////////
    // writes, later port wins on the same register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `QRISC_REG_CNT; i++)
                regs[i] <= '0;
        end
        else
        begin
            if (wb_ex.write_reg)                // execute result
                regs[wb_ex.dst_r] <= wb_ex.val_dst;
            if (wb_ex.incr_r2_enable)           // R2 auto increment
                regs[wb_ex.src_r2] <= wb_ex.val_r2;
            if (wb_mem.write_reg)               // memory read data
                regs[wb_mem.dst_r] <= wb_mem.val_dst;
        end
    end

    ////////////////////////////////////////////////////////////
    // reads
    ////////////////////////////////////////////////////////////

    assign rd_data = '{
        val_r1:  regs[rd_addr.r1],
        val_r2:  regs[rd_addr.r2],
        val_dst: regs[rd_addr.dst]
    };

    // an enabled write port must carry a known address
    wr_addr_known: assert property (
        @(posedge clk) disable iff (reset)
        (wb_ex.write_reg -> !$isunknown(wb_ex.dst_r)) &&
        (wb_ex.incr_r2_enable -> !$isunknown(wb_ex.src_r2)) &&
        (wb_mem.write_reg -> !$isunknown(wb_mem.dst_r))
    ) else $error("reg_file write with unknown address");

endmodule

// File: operand_forward.sv
// qrisc operand forwarding
// picks each operand from memory write-back, execute write-back or register file
`include "qrisc_defs.svh"
`timescale 1ns/1ns

module operand_forward (
    input  logic [`QRISC_DATA_W-1:0]  instruction,
    input  qrisc_pkg::wb_t            wb_ex,
    input  qrisc_pkg::wb_t            wb_mem,
    output qrisc_pkg::rd_addr_t       rd_addr,
    input  qrisc_pkg::operand_t       rd_data,
    output qrisc_pkg::operand_t       operands
);
    import qrisc_pkg::*;

    // first match wins: mem dst, ex dst, ex R2 increment, register file
    function automatic logic [`QRISC_DATA_W-1:0] fwd(
        input reg_addr_t                 addr,
        input logic [`QRISC_DATA_W-1:0]  rf_val,
        input wb_t                       ex,
        input wb_t                       mem
    );
        if (mem.write_reg && mem.dst_r == addr)
            return mem.val_dst;
        else if (ex.write_reg && ex.dst_r == addr)
            return ex.val_dst;
        else if (ex.incr_r2_enable && ex.src_r2 == addr)
            return ex.val_r2;       // incremented R2 not yet stored
        else
            return rf_val;
    endfunction

    ////////////////////////////////////////////////////////////
    // register fields out to the register file
    ////////////////////////////////////////////////////////////

    assign rd_addr = '{
        r1:  instruction[`QRISC_SRC1_F],
        r2:  instruction[`QRISC_SRC2_F],
        dst: instruction[`QRISC_DST_F]
    };

    ////////////////////////////////////////////////////////////
    // forwarded operands
    ////////////////////////////////////////////////////////////

    assign operands = '{
        val_r1:  fwd(rd_addr.r1, rd_data.val_r1, wb_ex, wb_mem),
        val_r2:  fwd(rd_addr.r2, rd_data.val_r2, wb_ex, wb_mem),
        val_dst: fwd(rd_addr.dst, rd_data.val_dst, wb_ex, wb_mem)
    };

endmodule

// File: instr_decoder.sv
// qrisc instruction decoder
// turns instruction, pc and forwarded operands into pipeline control and values,
// registered into pipe_out unless the memory stage stalls
`include "qrisc_defs.svh"
`timescale 1ns/1ns

module instr_decoder (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`QRISC_DATA_W-1:0]  instruction,
    input  logic [`QRISC_DATA_W-1:0]  pc,
    input  logic                      stall,
    input  qrisc_pkg::operand_t       operands,
    output qrisc_pkg::pipe_t          pipe_out
);
    import qrisc_pkg::*;

    pipe_t                     dec;        // next pipe_out
    opcode_e                   opcode;
    logic [1:0]                sub_op;
    logic [2:0]                incr_code;
    logic                      rofs;       // offset from R2
    logic [`QRISC_DATA_W-1:0]  offset;

    // sub-op to flag condition, shared by JMPF and LDRF
    function automatic jump_e flag_cond(input logic [1:0] sel);
        case (sel)
            2'd0:    return JMP_Z;
            2'd1:    return JMP_NZ;
            2'd2:    return JMP_C;
            default: return JMP_NC;
        endcase
    endfunction

    function automatic alu_op_e alu_decode(input logic [2:0] code);
        case (code)
            3'd0:    return ALU_AND;
            3'd1:    return ALU_OR;
            3'd2:    return ALU_XOR;
            3'd3:    return ALU_ADD;
            3'd4:    return ALU_MUL;
            3'd5:    return ALU_SHL;
            3'd6:    return ALU_SHR;
            default: return ALU_CMP;
        endcase
    endfunction

    assign opcode    = opcode_e'(instruction[`QRISC_OPCODE_F]);
    assign sub_op    = instruction[`QRISC_SUBOP_F];
    assign incr_code = instruction[`QRISC_INCR_F];
    assign rofs      = instruction[`QRISC_ROFS_BIT];
    assign offset    = rofs ? operands.val_r2 :
                       {{(`QRISC_DATA_W-`QRISC_OFS_W){instruction[`QRISC_OFS_SIGN]}},
                        instruction[`QRISC_OFS_F]};

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        dec          = '0;
        dec.dst_r    = instruction[`QRISC_DST_F];
        dec.src_r1   = instruction[`QRISC_SRC1_F];
        dec.src_r2   = instruction[`QRISC_SRC2_F];
        dec.val_r1   = operands.val_r1;
        dec.val_r2   = operands.val_r2;
        dec.val_dst  = operands.val_dst;
        dec.alu_op   = ALU_NONE;
        dec.jmp_cond = JMP_NONE;

        case (incr_code)
            3'd1:    dec.incr_r2 = 4'sd1;
            3'd2:    dec.incr_r2 = 4'sd2;
            3'd3:    dec.incr_r2 = 4'sd4;
            3'd5:    dec.incr_r2 = -4'sd1;
            3'd6:    dec.incr_r2 = -4'sd2;
            3'd7:    dec.incr_r2 = -4'sd4;
            default: dec.incr_r2 = 4'sd0;   // codes 0 and 4
        endcase
        dec.incr_r2_enable = (incr_code[1:0] != 2'b00);

        case (opcode)
            OP_LDR:
            begin
                case (sub_op)
                    2'd0:   // register move
                    begin
                        dec.write_reg = (dec.dst_r != dec.src_r1);
                        dec.val_dst   = operands.val_r1;
                    end
                    2'd1:   // halfword high
                    begin
                        dec.val_dst[`QRISC_DATA_W-1 -: `QRISC_HALF_W] =
                            instruction[`QRISC_HALF_F];
                        dec.write_reg      = 1'b1;
                        dec.incr_r2_enable = 1'b0;
                    end
                    2'd2:   // halfword low
                    begin
                        dec.val_dst[`QRISC_HALF_W-1:0] = instruction[`QRISC_HALF_F];
                        dec.write_reg      = 1'b1;
                        dec.incr_r2_enable = 1'b0;
                    end
                    default: // load from memory
                    begin
                        dec.read_mem       = 1'b1;
                        dec.write_reg      = 1'b1;
                        dec.incr_r2_enable = rofs;
                        dec.val_r2         = offset;
                    end
                endcase
            end
            OP_STR:
            begin
                dec.write_mem      = 1'b1;
                dec.val_r2         = offset;
                dec.incr_r2_enable = rofs;
            end
            OP_JMPUNC:
            begin
                dec.jmp_cond       = JMP_UNC;
                dec.incr_r2_enable = rofs;
                case (sub_op)
                    2'd0:   // absolute
                    begin
                        dec.val_r1 = '0;
                        dec.val_r1[`QRISC_TARGET_W-1:0] = instruction[`QRISC_TARGET_F];
                        dec.val_r2         = '0;
                        dec.incr_r2_enable = 1'b0;
                    end
                    2'd1:   // relative
                    begin
                        dec.val_r1 = pc;
                        dec.val_r2 = offset;
                    end
                    2'd2:   // call, return address to dst
                    begin
                        dec.val_r1    = pc;
                        dec.val_r2    = offset;
                        dec.val_dst   = pc;
                        dec.write_reg = 1'b1;
                    end
                    default: // return through dst register
                    begin
                        dec.val_r1 = operands.val_dst;
                        dec.val_r2 = '0;
                    end
                endcase
            end
            OP_JMPF:
            begin
                dec.val_r1         = pc;
                dec.val_r2         = offset;
                dec.incr_r2_enable = rofs;
                dec.jmp_cond       = flag_cond(sub_op);
            end
            OP_ALU:
            begin
                dec.alu_op    = alu_decode(instruction[`QRISC_ALUOP_F]);
                dec.write_reg = (dec.alu_op != ALU_CMP);   // cmp only sets flags
            end
            OP_LDRF:
            begin
                dec.ldrf_op   = 1'b1;
                dec.write_reg = 1'b1;
                dec.jmp_cond  = flag_cond(sub_op);
            end
            default: // nop and undefined codes
                dec = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset)
            pipe_out <= '0;
        else if (!stall)
            pipe_out <= dec;    // hold while memory stage stalls
    end

    mem_rw_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(pipe_out.read_mem && pipe_out.write_mem)
    ) else $error("read_mem and write_mem both set");

    stall_hold: assert property (
        @(posedge clk) disable iff (reset)
        stall |=> $stable(pipe_out)
    ) else $error("pipe_out changed during stall");

endmodule

// File: qrisc_decode_stage.sv
// qrisc instruction decode stage
// register file, operand forwarding and decoder with its output register
`include "qrisc_defs.svh"
`timescale 1ns/1ns

module qrisc_decode_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [`QRISC_DATA_W-1:0]  instruction,
    input  logic [`QRISC_DATA_W-1:0]  pc,
    input  logic                      stall,      // from memory stage
    input  qrisc_pkg::wb_t            wb_ex,
    input  qrisc_pkg::wb_t            wb_mem,
    output qrisc_pkg::pipe_t          pipe_out
);
    import qrisc_pkg::*;

    rd_addr_t  rd_addr;
    operand_t  rd_data;     // raw register file values
    operand_t  operands;    // after forwarding

    ////////////////////////////////////////////////////////////
    // register file and forwarding
    ////////////////////////////////////////////////////////////

    reg_file reg_file_i (
        .clk     (clk),
        .reset   (reset),
        .wb_ex   (wb_ex),
        .wb_mem  (wb_mem),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    operand_forward operand_forward_i (
        .instruction (instruction),
        .wb_ex       (wb_ex),
        .wb_mem      (wb_mem),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .operands    (operands)
    );

    ////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////

    instr_decoder instr_decoder_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .stall       (stall),
        .operands    (operands),
        .pipe_out    (pipe_out)
    );

endmodule

// File: tb_clock_gen.sv
// testbench clock and reset
// free running clock, reset held high for the first cycles
`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD       = 40,   // ns
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic reset
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;      // released on a rising edge
    end

endmodule

// File: tb_qrisc_decode_stage.sv
// testbench for the qrisc decode stage
// replays decode_stimulus.txt and checks pipe_out one cycle after each vector
`include "qrisc_defs.svh"
`timescale 1ns/1ns

module tb_qrisc_decode_stage;
    import qrisc_pkg::*;

    localparam int RESET_TIMEOUT = 20;     // cycles

    logic                      clk;
    logic                      reset;
    logic [`QRISC_DATA_W-1:0]  instruction;
    logic [`QRISC_DATA_W-1:0]  pc;
    logic                      stall;
    wb_t                       wb_ex;
    wb_t                       wb_mem;
    pipe_t                     pipe_out;
    int                        check_line;  // stimulus line being checked

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(4)) tb_clock_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    qrisc_decode_stage qrisc_decode_stage_i (
        .clk         (clk),
        .reset       (reset),
        .instruction (instruction),
        .pc          (pc),
        .stall       (stall),
        .wb_ex       (wb_ex),
        .wb_mem      (wb_mem),
        .pipe_out    (pipe_out)
    );

    ////////////////////////////////////////////////////////////
    // checking
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("** Error: %s = %h, expected %h (stimulus line %0d)",
                                name, got, exp, check_line));
    endtask

    task automatic check_ctrl(input pipe_t got, input pipe_t exp);
        compare_field("pipe_out.dst_r", got.dst_r, exp.dst_r);
        compare_field("pipe_out.src_r1", got.src_r1, exp.src_r1);
        compare_field("pipe_out.src_r2", got.src_r2, exp.src_r2);
        compare_field("pipe_out.incr_r2", $unsigned(got.incr_r2), $unsigned(exp.incr_r2));
        compare_field("pipe_out.incr_r2_enable", got.incr_r2_enable, exp.incr_r2_enable);
        compare_field("pipe_out.read_mem", got.read_mem, exp.read_mem);
        compare_field("pipe_out.write_mem", got.write_mem, exp.write_mem);
        compare_field("pipe_out.write_reg", got.write_reg, exp.write_reg);
        compare_field("pipe_out.alu_op", got.alu_op, exp.alu_op);
        compare_field("pipe_out.jmp_cond", got.jmp_cond, exp.jmp_cond);
        compare_field("pipe_out.ldrf_op", got.ldrf_op, exp.ldrf_op);
    endtask

    task automatic check_values(input operand_t got, input operand_t exp);
        compare_field("pipe_out.val_r1", got.val_r1, exp.val_r1);
        compare_field("pipe_out.val_r2", got.val_r2, exp.val_r2);
        compare_field("pipe_out.val_dst", got.val_dst, exp.val_dst);
    endtask

    function automatic operand_t vals_of(input pipe_t p);
        return '{val_r1: p.val_r1, val_r2: p.val_r2, val_dst: p.val_dst};
    endfunction

    task automatic check_pipe_out(input pipe_t exp);
        check_ctrl(pipe_out, exp);
        check_values(vals_of(pipe_out), vals_of(exp));
    endtask

    // register fields pass through for valid groups, nop and bad codes clear them
    function automatic rd_addr_t expected_regs(input logic [31:0] instr);
        logic [3:0] op;
        op = instr[`QRISC_OPCODE_F];
        if (op >= 4'd1 && op <= 4'd6)
            return '{r1: instr[`QRISC_SRC1_F], r2: instr[`QRISC_SRC2_F],
                     dst: instr[`QRISC_DST_F]};
        else
            return '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////

    initial
    begin
        int           fd;
        int           n;
        int           line_no;
        int           pending_line;
        int           waited;
        string        line;
        logic [31:0]  f_instr, f_pc, f_stall, f_exw, f_exv, f_exv2;
        logic [31:0]  f_memw, f_memv, f_ctrl, f_v1, f_v2, f_vd;
        rd_addr_t     exp_regs;
        pipe_t        exp_pending;
        bit           have_pending;

        instruction  = '0;
        pc           = '0;
        stall        = 1'b0;
        wb_ex        = '0;
        wb_mem       = '0;
        exp_regs     = '0;
        exp_pending  = '0;
        have_pending = 1'b0;
        line_no      = 0;
        pending_line = 0;
        waited       = 0;
        check_line   = 0;

        @(negedge clk);
        while (reset)
        begin
            if (waited == RESET_TIMEOUT)
                abort_run("reset was not released within the timeout");
            waited++;
            @(negedge clk);
        end
        check_pipe_out('0);     // reset state

        fd = $fopen("decode_stimulus.txt", "r");
        if (fd == 0)
            abort_run("could not open decode_stimulus.txt");

        while (!$feof(fd))
        begin
            line = "";
            n = $fgets(line, fd);
            line_no++;
            if (n > 0 && line.len() > 0 && line[0] != "#")
            begin
                n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                            f_instr, f_pc, f_stall, f_exw, f_exv, f_exv2,
                            f_memw, f_memv, f_ctrl, f_v1, f_v2, f_vd);
                if (n == 12)
                begin
                    @(posedge clk);
                    instruction <= f_instr;
                    pc          <= f_pc;
                    stall       <= f_stall[0];
                    wb_ex       <= '{write_reg: f_exw[20], dst_r: f_exw[16:12],
                                     val_dst: f_exv, incr_r2_enable: f_exw[8],
                                     src_r2: f_exw[4:0], val_r2: f_exv2};
                    wb_mem      <= '{write_reg: f_memw[8], dst_r: f_memw[4:0],
                                     val_dst: f_memv, incr_r2_enable: 1'b0,
                                     src_r2: '0, val_r2: '0};

                    @(negedge clk);     // previous vector has reached pipe_out
                    if (have_pending)
                    begin
                        check_line = pending_line;
                        check_pipe_out(exp_pending);
                    end

                    if (!f_stall[0])
                        exp_regs = expected_regs(f_instr);  // held during stall
                    exp_pending                = '0;
                    exp_pending.dst_r          = exp_regs.dst;
                    exp_pending.src_r1         = exp_regs.r1;
                    exp_pending.src_r2         = exp_regs.r2;
                    exp_pending.val_r1         = f_v1;
                    exp_pending.val_r2         = f_v2;
                    exp_pending.val_dst        = f_vd;
                    exp_pending.incr_r2        = f_ctrl[31:28];
                    exp_pending.incr_r2_enable = f_ctrl[24];
                    exp_pending.read_mem       = f_ctrl[20];
                    exp_pending.write_mem      = f_ctrl[16];
                    exp_pending.write_reg      = f_ctrl[12];
                    exp_pending.alu_op         = alu_op_e'(f_ctrl[11:8]);
                    exp_pending.jmp_cond       = jump_e'(f_ctrl[6:4]);
                    exp_pending.ldrf_op        = f_ctrl[0];
                    pending_line = line_no;
                    have_pending = 1'b1;
                end
            end
        end
        $fclose(fd);

        if (!have_pending)
            abort_run("no vectors found in decode_stimulus.txt");

        // flush the last vector
        @(posedge clk);
        instruction <= '0;
        stall       <= 1'b0;
        wb_ex       <= '0;
        wb_mem      <= '0;
        @(negedge clk);
        check_line = pending_line;
        check_pipe_out(exp_pending);

        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: qrisc_decode_stage.f
+incdir+.
qrisc_pkg.sv
reg_file.sv
operand_forward.sv
instr_decoder.sv
qrisc_decode_stage.sv
tb_clock_gen.sv
tb_qrisc_decode_stage.sv

// File: decode_stimulus.txt
# instr pc stall ex_ctl ex_val ex_val2 mem_ctl mem_val exp_ctl exp_r1 exp_r2 exp_dst (all hex)
# ex_ctl nibbles {write_reg, dst_r x2, incr_r2_enable, src_r2 x2}, mem_ctl {write_reg, dst_r x2}
# exp_ctl nibbles {incr_r2, incr_en, read_mem, write_mem, write_reg, alu_op, jmp_cond, ldrf_op}
00000000 0 0 000000 0 0 000 0 00000000 0 0 0
56000823 0 0 000000 0 0 000 0 00001400 0 0 0
# write-backs stored, then read by alu and cmp
00000000 0 0 101102 11111111 22222222 103 33333333 00000000 0 0 0
56000823 0 0 000000 0 0 000 0 00001400 11111111 22222222 33333333
5e000823 0 0 000000 0 0 000 0 00000800 11111111 22222222 33333333
# forwarding priority on colliding write-backs
56000823 0 0 101101 a1a1a1a1 b1b1b1b1 101 c1c1c1c1 00001400 c1c1c1c1 22222222 33333333
56000823 0 0 102102 a2a2a2a2 b2b2b2b2 000 0 00001400 c1c1c1c1 a2a2a2a2 33333333
56000823 0 0 105103 55555555 d3d3d3d3 000 0 00001400 c1c1c1c1 b2b2b2b2 d3d3d3d3
# moves, halfwords, loads and stores
10000024 0 0 000000 0 0 000 0 00001000 c1c1c1c1 0 c1c1c1c1
10000021 0 0 000000 0 0 000 0 00000000 c1c1c1c1 0 c1c1c1c1
1417dde5 0 0 000000 0 0 000 0 00001000 0 0 beef5555
18024685 0 0 000000 0 0 000 0 00001000 0 0 55551234
1dffe024 0 0 000000 0 0 000 0 c0101000 c1c1c1c1 fffffff8 0
1e400824 0 0 000000 0 0 000 0 11101000 c1c1c1c1 b2b2b2b2 0
20004023 0 0 000000 0 0 000 0 00010000 c1c1c1c1 10 d3d3d3d3
22800823 0 0 000000 0 0 000 0 21010000 c1c1c1c1 b2b2b2b2 d3d3d3d3
# increment codes 0 to 7 on alu and
50000823 0 0 000000 0 0 000 0 00001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
50400823 0 0 000000 0 0 000 0 11001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
50800823 0 0 000000 0 0 000 0 21001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
50c00823 0 0 000000 0 0 000 0 41001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
51000823 0 0 000000 0 0 000 0 00001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
51400823 0 0 000000 0 0 000 0 f1001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
51800823 0 0 000000 0 0 000 0 e1001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
51c00823 0 0 000000 0 0 000 0 c1001100 c1c1c1c1 b2b2b2b2 d3d3d3d3
# jumps, flag loads and an invalid opcode
32abcdef 1000 0 000000 0 0 000 0 20000010 02abcdef 0 0
35ff8000 1000 0 000000 0 0 000 0 c0000010 1000 ffffffe0 0
3b400807 2000 0 000000 0 0 000 0 f1001010 2000 b2b2b2b2 2000
3c000003 2000 0 000000 0 0 000 0 00000010 d3d3d3d3 0 d3d3d3d3
40001000 3000 0 000000 0 0 000 0 00000020 3000 4 0
44000000 3000 0 000000 0 0 000 0 00000030 3000 0 0
48000000 3000 0 000000 0 0 000 0 00000040 3000 0 0
4e400400 3000 0 000000 0 0 000 0 11000050 3000 c1c1c1c1 0
60000823 0 0 000000 0 0 000 0 00001021 c1c1c1c1 b2b2b2b2 d3d3d3d3
68c00823 0 0 000000 0 0 000 0 41001041 c1c1c1c1 b2b2b2b2 d3d3d3d3
f2abcdef 0 0 000000 0 0 000 0 00000000 0 0 0
# stall holds pipe_out while the register file still writes
56000823 0 0 000000 0 0 000 0 00001400 c1c1c1c1 b2b2b2b2 d3d3d3d3
60000823 0 1 000000 0 0 000 0 00001400 c1c1c1c1 b2b2b2b2 d3d3d3d3
40001000 3000 1 109000 99999999 0 000 0 00001400 c1c1c1c1 b2b2b2b2 d3d3d3d3
1e400824 0 1 000000 0 0 000 0 00001400 c1c1c1c1 b2b2b2b2 d3d3d3d3
22800823 0 0 000000 0 0 000 0 21010000 c1c1c1c1 b2b2b2b2 d3d3d3d3
56002529 0 0 000000 0 0 000 0 00001400 99999999 99999999 99999999
